/* Makefile */
TOP := upstream_processor_tb

.PHONY: all run lint clean

all: run

# pass only if the simulation prints the pass line
run:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall +incdir+hw \
		hw/risk_order_pkg.sv hw/risk_ctrl_pkg.sv hw/client_ram.sv \
		hw/upstream_ctrl.sv hw/upstream_processor_top.sv \
		--top-module upstream_processor_top

clean:
	rm -rf obj_dir

/* hw/client_ram.sv */
// per-client table with one write port and one registered read port on one clock
// read data follows the address by one cycle
// entries not written since reset read back as zero
// write and read of the same entry in one cycle returns the old data
`timescale 1ns/1ps
`default_nettype none
`include "risk_defines.svh"

module client_ram #(
  parameter type payload_t = risk_order_pkg::amount_t
) (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire                             wr_en,
  input  wire risk_order_pkg::client_id_t wr_addr,
  input  wire payload_t                   wr_data,
  input  wire risk_order_pkg::client_id_t rd_addr,
  output payload_t                        rd_data
);

  // storage itself holds no reset state
  payload_t mem [`RISK_CLIENTS];

  // set on first write to an entry
  logic [`RISK_CLIENTS-1:0] valid;

  // valid bits are the only state that reset touches
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid <= '0; // every entry reads as zero
    end
    else if (wr_en)
    begin
      valid[wr_addr] <= 1'b1;
    end
  end

  // write port
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, sees contents from before this edge
  always_ff @(posedge clk)
  begin
    if (valid[rd_addr])
    begin
      rd_data <= mem[rd_addr];
    end
    else
    begin
      rd_data <= '0; // never written
    end
  end

endmodule

`default_nettype wire

/* hw/risk_ctrl_pkg.sv */
// control side types for the upstream controller
// state code 2'd3 is unused and falls back to idle
`default_nettype none

package risk_ctrl_pkg;

  // controller walk per request
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0, // waiting for a strobe
    ST_READ   = 2'd1, // address at both tables
    ST_DECIDE = 2'd2  // read data back, decide and write
  } ctrl_state_t;

  // what the captured strobe asked for
  typedef enum logic [0:0] {
    REQ_ORDER = 1'b0, // check order against limit
    REQ_MAX   = 1'b1  // rewrite limit only
  } req_kind_t;

endpackage

`default_nettype wire

/* hw/risk_defines.svh */
// sizes shared by the client tables and the order path
// client bits and table depth must agree (depth is 2**bits)
// amounts are unsigned and sums are assumed to fit in one extra bit
`ifndef RISK_DEFINES_SVH
`define RISK_DEFINES_SVH

// client index width
`define RISK_CLIENT_BITS 5

// order volume and limit width
`define RISK_AMOUNT_BITS 32

// entries per table, one per client
`define RISK_CLIENTS 32

`endif

/* hw/risk_order_pkg.sv */
// order side types used by both tables and the controller
// widths follow the defines header
// ledger entry packs accumulated volume above the trading maximum
`default_nettype none
`include "risk_defines.svh"

package risk_order_pkg;

  // client index into either table
  typedef logic [`RISK_CLIENT_BITS-1:0] client_id_t;

  // order volume, limit or cancelled total
  typedef logic [`RISK_AMOUNT_BITS-1:0] amount_t;

  // one ledger row per client
  typedef struct packed {
    amount_t accumulated;  // volume passed so far
    amount_t max_to_trade; // client limit
  } ledger_entry_t;

endpackage

`default_nettype wire

/* hw/upstream_ctrl.sv */
// request capture, table lookup and risk decision for the upstream gate
// one request in flight and a strobe arriving while busy is dropped
// new_order and new_max are assumed mutually exclusive
// volume plus amount and limit plus cancelled must each fit in 33 bits
`timescale 1ns/1ps
`default_nettype none
`include "risk_defines.svh"

module upstream_ctrl (
  input  wire                                clk,
  input  wire                                arst_n,
  input  wire                                new_order,
  input  wire                                new_max,
  input  wire risk_order_pkg::client_id_t    client_id,
  input  wire risk_order_pkg::amount_t       amount,
  input  wire risk_order_pkg::ledger_entry_t ledger_rd,
  input  wire risk_order_pkg::amount_t       cancelled,
  output risk_order_pkg::client_id_t         lookup_client,
  output logic                               ledger_we,
  output risk_order_pkg::ledger_entry_t      ledger_wr,
  output logic                               order_accepted,
  output logic                               order_rejected,
  output logic                               max_updated,
  output logic                               busy
);
  import risk_order_pkg::*;
  import risk_ctrl_pkg::*;

  // one guard bit above the amount width
  localparam int unsigned SUM_BITS = `RISK_AMOUNT_BITS + 1;

  ctrl_state_t state;
  ctrl_state_t state_nxt;

  // captured request
  req_kind_t  kind_q;
  client_id_t client_q;
  amount_t    amount_q; // payload, no reset

  logic                take_req;
  logic                decide;
  logic                is_order;
  logic [SUM_BITS-1:0] exposure; // accumulated plus order
  logic [SUM_BITS-1:0] headroom; // max plus cancelled
  logic                risk_ok;
  amount_t             acc_nxt;

  // only an idle controller listens
  assign take_req = (state == ST_IDLE) && (new_order || new_max);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      state <= state_nxt;
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (take_req)
        begin
          state_nxt = ST_READ;
        end
      end
      ST_READ:   state_nxt = ST_DECIDE; // address sits at both tables
      ST_DECIDE: state_nxt = ST_IDLE;   // write lands on this edge
      default:   state_nxt = ST_IDLE;
    endcase
  end

  // client and kind reset so the lookup address is known when idle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      client_q <= '0;
      kind_q   <= REQ_ORDER;
    end
    else if (take_req)
    begin
      client_q <= client_id;
      kind_q   <= new_max ? REQ_MAX : REQ_ORDER;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take_req)
    begin
      amount_q <= amount;
    end
  end

  // same index reads ledger and cancel table and writes the ledger
  assign lookup_client = client_q;

  assign busy     = (state != ST_IDLE); // cycles 1 and 2
  assign decide   = (state == ST_DECIDE);
  assign is_order = (kind_q == REQ_ORDER);

  // accumulated + amount - cancelled <= max
  // cancelled moved to the right side so nothing wraps below zero
  assign exposure = {1'b0, ledger_rd.accumulated} + {1'b0, amount_q};
  assign headroom = {1'b0, ledger_rd.max_to_trade} + {1'b0, cancelled};
  assign risk_ok  = (exposure <= headroom);

  // new volume, top bit dropped by the size assumption
  assign acc_nxt = exposure[`RISK_AMOUNT_BITS-1:0];

  // exactly one of these in the decide cycle
  assign order_accepted = decide && is_order && risk_ok;
  assign order_rejected = decide && is_order && !risk_ok;
  assign max_updated    = decide && !is_order;

  // failed order leaves the row alone
  assign ledger_we = order_accepted || max_updated;

  // start from the row as read and change one field
  always_comb
  begin
    ledger_wr = ledger_rd;
    if (is_order)
    begin
      ledger_wr.accumulated = acc_nxt;
    end
    else
    begin
      ledger_wr.max_to_trade = amount_q; // accumulated kept
    end
  end

endmodule

`default_nettype wire

/* hw/upstream_processor_top.sv */
// pre-trade risk gate for up to 32 clients
// cancel table is owned downstream and written through the cxl ports at any time
// request strobes while busy are dropped and there is no back-pressure
// accumulated and max_to_trade are for observation and meaningful in the result cycle
`timescale 1ns/1ps
`default_nettype none

module upstream_processor_top (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire                             new_order,
  input  wire                             new_max,
  input  wire risk_order_pkg::client_id_t client_id,
  input  wire risk_order_pkg::amount_t    amount,
  input  wire                             cxl_write,
  input  wire risk_order_pkg::client_id_t cxl_client,
  input  wire risk_order_pkg::amount_t    cxl_total,
  output logic                            order_accepted,
  output logic                            order_rejected,
  output logic                            max_updated,
  output logic                            busy,
  output risk_order_pkg::amount_t         accumulated,
  output risk_order_pkg::amount_t         max_to_trade
);
  import risk_order_pkg::*;

  client_id_t    lookup_client; // shared table index
  ledger_entry_t ledger_rd;
  ledger_entry_t ledger_wr;
  logic          ledger_we;
  amount_t       cancelled;     // cancel table read data

  // volume and limit per client, written only by the controller
  client_ram #(
    .payload_t(ledger_entry_t)
  ) ledger_ram (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (ledger_we),
    .wr_addr (lookup_client),
    .wr_data (ledger_wr),
    .rd_addr (lookup_client),
    .rd_data (ledger_rd)
  );

  // absolute cancelled total per client
  client_ram #(
    .payload_t(amount_t)
  ) cancel_ram (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (cxl_write), // not blocked by busy
    .wr_addr (cxl_client),
    .wr_data (cxl_total),
    .rd_addr (lookup_client),
    .rd_data (cancelled)
  );

  upstream_ctrl ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .new_order      (new_order),
    .new_max        (new_max),
    .client_id      (client_id),
    .amount         (amount),
    .ledger_rd      (ledger_rd),
    .cancelled      (cancelled),
    .lookup_client  (lookup_client),
    .ledger_we      (ledger_we),
    .ledger_wr      (ledger_wr),
    .order_accepted (order_accepted),
    .order_rejected (order_rejected),
    .max_updated    (max_updated),
    .busy           (busy)
  );

  // row as read in the decide cycle
  assign accumulated  = ledger_rd.accumulated;
  assign max_to_trade = ledger_rd.max_to_trade;

endmodule

`default_nettype wire

/* test/upstream_processor_sva.sv */
// request and result strobe timing, sampled on the rising clock edge
// a request counts only when the gate is idle, strobes while busy are ignored
// all checks are off while arst_n is low
`timescale 1ns/1ps
`default_nettype none

module upstream_processor_sva (
  input wire clk,
  input wire arst_n,
  input wire new_order,
  input wire new_max,
  input wire busy,
  input wire order_accepted,
  input wire order_rejected,
  input wire max_updated
);

  logic req_taken;  // strobe seen by an idle gate
  logic any_result;

  assign req_taken  = (new_order || new_max) && !busy;
  assign any_result = order_accepted || order_rejected || max_updated;

  // exactly one strobe in cycle 2
  a_one_result: assert property (@(posedge clk) disable iff (!arst_n)
    $past(req_taken, 2) |-> $onehot({order_accepted, order_rejected, max_updated}))
  else $error("missing or multiple result strobes two cycles after a request");

  // no strobe without a request behind it
  a_result_has_req: assert property (@(posedge clk) disable iff (!arst_n)
    any_result |-> $past(req_taken, 2))
  else $error("result strobe without a request two cycles earlier");

  a_strobes_onehot0: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({order_accepted, order_rejected, max_updated}))
  else $error("more than one result strobe in one cycle");

  // busy in cycles 1 and 2
  a_busy_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    ($past(req_taken) || $past(req_taken, 2)) |-> busy)
  else $error("busy low in the two cycles after a request");

  // and nowhere else
  a_busy_only_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    busy |-> ($past(req_taken) || $past(req_taken, 2)))
  else $error("busy high outside the two cycles after a request");

endmodule

bind upstream_processor_top upstream_processor_sva sva_inst (
  .clk            (clk),
  .arst_n         (arst_n),
  .new_order      (new_order),
  .new_max        (new_max),
  .busy           (busy),
  .order_accepted (order_accepted),
  .order_rejected (order_rejected),
  .max_updated    (max_updated)
);

`default_nettype wire

/* test/upstream_processor_tb.sv */
// directed table then seeded random requests, checked against a reference model
// requests are spaced so none lands while busy, except the deliberate drop row
// cancel writes never overlap a lookup of the same client
`timescale 1ns/1ps
`default_nettype none
`include "risk_defines.svh"

module upstream_processor_tb;
  import risk_order_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_ROWS       = 16;
  localparam int N_RANDOM     = 40;
  localparam int GAP_CYCLES   = 4;
  localparam int RESULT_WAIT  = 4; // give up on a result after this
  // six cycles per request at most, reset counted twice for margin
  localparam int WATCHDOG_NS  = (N_ROWS + N_RANDOM) * 6 * CLK_PERIOD
                                + 2 * RESET_CYCLES * CLK_PERIOD;

  typedef enum int {OP_ORDER, OP_MAX, OP_CANCEL, OP_DROP} op_t;
  typedef enum int {RES_NONE, RES_ACC, RES_REJ, RES_MAX} res_t;

  typedef struct {
    string name;
    op_t   op;
    int    client;
    int    amount;
    res_t  exp;
  } row_t;

  // drop row: order plus a second strobe while busy
  row_t rows [N_ROWS] = '{
    '{"first_order_zero_max", OP_ORDER,  0,   5, RES_REJ},
    '{"max_c0",               OP_MAX,    0, 100, RES_MAX},
    '{"order_c0_a",           OP_ORDER,  0,  60, RES_ACC},
    '{"order_c0_to_max",      OP_ORDER,  0,  40, RES_ACC}, // exactly at max
    '{"order_c0_over_by_one", OP_ORDER,  0,   1, RES_REJ},
    '{"max_c0_raise",         OP_MAX,    0, 150, RES_MAX}, // volume kept
    '{"order_c0_b",           OP_ORDER,  0,  50, RES_ACC},
    '{"order_c0_over",        OP_ORDER,  0,  10, RES_REJ},
    '{"cancel_c0",            OP_CANCEL, 0,  20, RES_NONE},
    '{"order_c0_after_cxl",   OP_ORDER,  0,  10, RES_ACC},
    '{"order_c1_untouched",   OP_ORDER,  1,  10, RES_REJ},
    '{"max_c1",               OP_MAX,    1,  30, RES_MAX},
    '{"drop_while_busy_c1",   OP_DROP,   1,  30, RES_ACC},
    '{"order_c1_after_drop",  OP_ORDER,  1,   1, RES_REJ}, // dropped order left no trace
    '{"max_c31",              OP_MAX,   31,   5, RES_MAX},
    '{"order_c31",            OP_ORDER, 31,   5, RES_ACC}
  };

  logic       clk = 1'b0;
  logic       arst_n;
  logic       new_order;
  logic       new_max;
  client_id_t client_id;
  amount_t    amount;
  logic       cxl_write;
  client_id_t cxl_client;
  amount_t    cxl_total;
  logic       order_accepted;
  logic       order_rejected;
  logic       max_updated;
  logic       busy;
  amount_t    accumulated;
  amount_t    max_to_trade;

  // reference ledger and cancel table
  amount_t model_acc [`RISK_CLIENTS];
  amount_t model_max [`RISK_CLIENTS];
  amount_t model_cxl [`RISK_CLIENTS];

  int          checks     = 0;
  int          mismatches = 0;
  int          failures   = 0; // anything that is not a wrong value
  logic [31:0] rng_state  = 32'd2;

  always #(CLK_PERIOD / 2) clk = ~clk;

  upstream_processor_top upstream_processor_top_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .new_order      (new_order),
    .new_max        (new_max),
    .client_id      (client_id),
    .amount         (amount),
    .cxl_write      (cxl_write),
    .cxl_client     (cxl_client),
    .cxl_total      (cxl_total),
    .order_accepted (order_accepted),
    .order_rejected (order_rejected),
    .max_updated    (max_updated),
    .busy           (busy),
    .accumulated    (accumulated),
    .max_to_trade   (max_to_trade)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string res_name(input res_t r);
    case (r)
      RES_ACC: return "accepted";
      RES_REJ: return "rejected";
      RES_MAX: return "max_updated";
      default: return "none";
    endcase
  endfunction

  // volume + amount - cancelled <= max, evaluated wide so nothing wraps
  function automatic res_t predict(input op_t op, input int c, input amount_t amt);
    longint net;
    if (op == OP_CANCEL)
    begin
      return RES_NONE;
    end
    if (op == OP_MAX)
    begin
      return RES_MAX;
    end
    net = longint'(model_acc[c]) + longint'(amt) - longint'(model_cxl[c]);
    return (net <= longint'(model_max[c])) ? RES_ACC : RES_REJ;
  endfunction

  function automatic void update_model(input op_t op, input int c, input amount_t amt,
                                       input res_t res);
    case (op)
      OP_MAX:    model_max[c] = amt;   // volume untouched
      OP_CANCEL: model_cxl[c] = amt;   // absolute total
      default:
      begin
        if (res == RES_ACC)
        begin
          model_acc[c] = model_acc[c] + amt;
        end
      end
    endcase
  endfunction

  function automatic res_t observed_result();
    if (order_accepted)
    begin
      return RES_ACC;
    end
    if (order_rejected)
    begin
      return RES_REJ;
    end
    if (max_updated)
    begin
      return RES_MAX;
    end
    return RES_NONE;
  endfunction

  task automatic clear_request();
    new_order = 1'b0;
    new_max   = 1'b0;
    cxl_write = 1'b0;
  endtask

  // gate must sit idle with no stray strobe
  task automatic check_idle_gap(input string name);
    repeat (GAP_CYCLES)
    begin
      @(negedge clk);
      checks++;
      assert (observed_result() == RES_NONE && !busy)
      else
      begin
        failures++;
        $display("unexpected result strobe or busy in idle gap after %s", name);
      end
    end
  endtask

  // called on a falling edge, drives the strobe right away
  task automatic apply_request(input string name, input op_t op, input int c,
                               input amount_t amt);
    res_t    exp;
    res_t    got;
    amount_t exp_acc;
    amount_t exp_max;
    int      waited;
    exp     = predict(op, c, amt);
    exp_acc = model_acc[c]; // outputs show the row before write-back
    exp_max = model_max[c];
    if (op == OP_CANCEL)
    begin
      cxl_write  = 1'b1;
      cxl_client = client_id_t'(c);
      cxl_total  = amt;
      @(negedge clk);
      clear_request();
      update_model(op, c, amt, exp);
      check_idle_gap(name);
    end
    else
    begin
      new_order = (op != OP_MAX);
      new_max   = (op == OP_MAX);
      client_id = client_id_t'(c);
      amount    = amt;
      @(negedge clk); // cycle 1
      checks++;
      assert (busy)
      else
      begin
        failures++;
        $display("busy did not rise one cycle after request %s", name);
      end
      if (op == OP_DROP)
      begin
        amount = 32'd1; // strobe held high, lands while busy
      end
      else
      begin
        clear_request();
      end
      waited = 0;
      got    = RES_NONE;
      while (got == RES_NONE && waited < RESULT_WAIT)
      begin
        @(negedge clk);
        clear_request();
        waited++;
        got = observed_result();
      end
      checks++;
      assert (got != RES_NONE)
      else
      begin
        failures++;
        $display("no result strobe within %0d cycles for %s", RESULT_WAIT, name);
      end
      if (got != RES_NONE)
      begin
        checks += 4;
        assert (got == exp)
        else
        begin
          mismatches++;
          $display("MISMATCH %s strobe expected %s actual %s", name, res_name(exp),
                   res_name(got));
        end
        assert (waited == 1)
        else
        begin
          mismatches++;
          $display("MISMATCH %s latency expected 2 actual %0d", name, waited + 1);
        end
        assert (accumulated == exp_acc)
        else
        begin
          mismatches++;
          $display("MISMATCH %s accumulated expected %0d actual %0d", name, exp_acc,
                   accumulated);
        end
        assert (max_to_trade == exp_max)
        else
        begin
          mismatches++;
          $display("MISMATCH %s max_to_trade expected %0d actual %0d", name, exp_max,
                   max_to_trade);
        end
      end
      update_model(op, c, amt, exp);
      check_idle_gap(name);
    end
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    int      r;
    int      c;
    res_t    exp_row;
    amount_t amt;
    arst_n     = 1'b0;
    new_order  = 1'b0;
    new_max    = 1'b0;
    client_id  = '0;
    amount     = '0;
    cxl_write  = 1'b0;
    cxl_client = '0;
    cxl_total  = '0;
    for (r = 0; r < `RISK_CLIENTS; r++)
    begin
      model_acc[r] = '0; // matches cleared valid bits
      model_max[r] = '0;
      model_cxl[r] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    checks++;
    assert (!busy && observed_result() == RES_NONE)
    else
    begin
      failures++;
      $display("busy or a result strobe is high right after reset");
    end
    for (r = 0; r < N_ROWS; r++)
    begin
      exp_row = predict(rows[r].op, rows[r].client, amount_t'(rows[r].amount));
      checks++;
      assert (exp_row == rows[r].exp)
      else
      begin
        failures++;
        $display("table row %s expects %s but the reference model gives %s", rows[r].name,
                 res_name(rows[r].exp), res_name(exp_row));
      end
      apply_request(rows[r].name, rows[r].op, rows[r].client, amount_t'(rows[r].amount));
    end
    // few clients so limits and volumes interact
    for (r = 0; r < N_RANDOM; r++)
    begin
      rng_state = lcg_step(rng_state);
      c = int'(rng_state[17:16]);
      if (rng_state[31:30] == 2'b00)
      begin
        amt = amount_t'(rng_state[27:19]); // new max up to 511
        apply_request($sformatf("random_%0d", r), OP_MAX, c, amt);
      end
      else
      begin
        amt = amount_t'(rng_state[25:20]); // order up to 63
        apply_request($sformatf("random_%0d", r), OP_ORDER, c, amt);
      end
    end
    $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/risk_order_pkg.sv
hw/risk_ctrl_pkg.sv
hw/client_ram.sv
hw/upstream_ctrl.sv
hw/upstream_processor_top.sv
test/upstream_processor_sva.sv
test/upstream_processor_tb.sv
